/* include/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define CORE_XLEN       32
`define CORE_REG_AW     5
`define CORE_OP_W       4

// Internal operation codes
`define CORE_OP_ADD     4'd0
`define CORE_OP_SUB     4'd1
`define CORE_OP_SLL     4'd2
`define CORE_OP_SLT     4'd3
`define CORE_OP_SLTU    4'd4
`define CORE_OP_XOR     4'd5
`define CORE_OP_SRL     4'd6
`define CORE_OP_SRA     4'd7
`define CORE_OP_OR      4'd8
`define CORE_OP_AND     4'd9
`define CORE_OP_MUL     4'd10

`define CORE_OPC_OP     7'b0110011
`define CORE_OPC_OP_IMM 7'b0010011

// One multiplier bit per cycle
`define CORE_MUL_STEPS  `CORE_XLEN

`endif

/* logic/core_ifs.sv */
`include "core_defines.svh"

// Decoded instruction into execute
interface dec_ex_if;
    logic                    valid;
    logic                    ready;
    logic [`CORE_OP_W-1:0]   op;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [`CORE_REG_AW-1:0] rs2;
    logic [`CORE_XLEN-1:0]   imm;
    logic                    use_imm;

    modport producer (output valid, op, rd, rs1, rs2, imm, use_imm,
                      input  ready);
    modport consumer (input  valid, op, rd, rs1, rs2, imm, use_imm,
                      output ready);
endinterface

// Executed instruction into result
interface ex_res_if;
    logic                    valid;
    logic                    ready;
    logic [`CORE_OP_W-1:0]   op;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   value;
    logic [`CORE_XLEN-1:0]   operand_b;

    modport producer (output valid, op, rd, value, operand_b,
                      input  ready);
    modport consumer (input  valid, op, rd, value, operand_b,
                      output ready);
endinterface

// Result stage state seen by the forwarding logic
interface bypass_if;
    // Stage occupied
    logic                    rd_valid;
    // Result final
    logic                    value_valid;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   value;

    modport source (output rd_valid, value_valid, rd, value);
    modport reader (input  rd_valid, value_valid, rd, value);
endinterface

/* logic/core_pkg.sv */
`include "core_defines.svh"

package core_pkg;

    // Register-register layout
    typedef struct packed {
        logic [6:0]              funct7;
        logic [`CORE_REG_AW-1:0] rs2;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } r_fields_t;

    // Register-immediate layout
    typedef struct packed {
        logic [11:0]             imm;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } i_fields_t;

    // Same 32-bit word, seen either way
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

/* logic/core_top.sv */
`include "core_defines.svh"

module core_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    i_instr_valid,
    input  core_pkg::instr_u        i_instr,
    output logic                    o_instr_ready,
    output logic                    o_commit_valid,
    output logic [`CORE_REG_AW-1:0] o_commit_rd,
    output logic [`CORE_XLEN-1:0]   o_commit_data
);

    dec_ex_if dec_ex_i ();
    ex_res_if ex_res_i ();
    bypass_if byp_i ();

    // Register file read ports
    logic [`CORE_REG_AW-1:0] rs1_sel;
    logic [`CORE_REG_AW-1:0] rs2_sel;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rs2_data;

    decode_stage decode_stage_i (
        .clk           (clk),
        .resetn        (resetn),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_instr_ready (o_instr_ready),
        .dec           (dec_ex_i.producer)
    );

    execute_stage execute_stage_i (
        .clk        (clk),
        .resetn     (resetn),
        .dec        (dec_ex_i.consumer),
        .res        (ex_res_i.producer),
        .byp        (byp_i.reader),
        .o_rs1_sel  (rs1_sel),
        .o_rs2_sel  (rs2_sel),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data)
    );

    result_stage result_stage_i (
        .clk            (clk),
        .resetn         (resetn),
        .res            (ex_res_i.consumer),
        .byp            (byp_i.source),
        .o_commit_valid (o_commit_valid),
        .o_commit_rd    (o_commit_rd),
        .o_commit_data  (o_commit_data)
    );

    // Write port follows the commit strobe
    reg_file reg_file_i (
        .clk       (clk),
        .resetn    (resetn),
        .i_ra_sel  (rs1_sel),
        .i_rb_sel  (rs2_sel),
        .o_ra_data (rs1_data),
        .o_rb_data (rs2_data),
        .i_w_en    (o_commit_valid),
        .i_w_sel   (o_commit_rd),
        .i_w_data  (o_commit_data)
    );

endmodule

/* logic/decode_stage.sv */
`include "core_defines.svh"

module decode_stage (
    input  logic             clk,
    input  logic             resetn,
    input  logic             i_instr_valid,
    input  core_pkg::instr_u i_instr,
    output logic             o_instr_ready,
    dec_ex_if.producer       dec
);

    logic                  accept;
    logic                  is_op;
    logic                  is_imm;
    logic                  legal;
    logic [`CORE_OP_W-1:0] base_op;
    logic [`CORE_OP_W-1:0] op;
    logic [`CORE_XLEN-1:0] imm_ext;

    assign o_instr_ready = !dec.valid || dec.ready;
    assign accept        = i_instr_valid && o_instr_ready;

    assign is_op   = i_instr.r.opcode == `CORE_OPC_OP;
    assign is_imm  = i_instr.i.opcode == `CORE_OPC_OP_IMM;
    assign imm_ext = {{(`CORE_XLEN-12){i_instr.i.imm[11]}}, i_instr.i.imm};

    // funct3 mapping shared by both forms
    always_comb begin
        case (i_instr.r.funct3)
            3'b000:  base_op = `CORE_OP_ADD;
            3'b001:  base_op = `CORE_OP_SLL;
            3'b010:  base_op = `CORE_OP_SLT;
            3'b011:  base_op = `CORE_OP_SLTU;
            3'b100:  base_op = `CORE_OP_XOR;
            3'b101:  base_op = `CORE_OP_SRL;
            3'b110:  base_op = `CORE_OP_OR;
            default: base_op = `CORE_OP_AND;
        endcase
    end

    always_comb begin
        op    = base_op;
        legal = 1'b0;
        if (is_op) begin
            case (i_instr.r.funct7)
                7'h00: legal = 1'b1;
                7'h20: begin
                    legal = i_instr.r.funct3 == 3'b000 || i_instr.r.funct3 == 3'b101;
                    op    = (i_instr.r.funct3 == 3'b000) ? `CORE_OP_SUB : `CORE_OP_SRA;
                end
                7'h01: begin
                    legal = i_instr.r.funct3 == 3'b000;
                    op    = `CORE_OP_MUL;
                end
                default: legal = 1'b0;
            endcase
        end else if (is_imm) begin
            legal = 1'b1;
            // Shift immediates keep funct7 in the upper immediate bits
            if (i_instr.i.funct3 == 3'b001) begin
                legal = i_instr.r.funct7 == 7'h00;
            end else if (i_instr.i.funct3 == 3'b101) begin
                legal = i_instr.r.funct7 == 7'h00 || i_instr.r.funct7 == 7'h20;
                if (i_instr.r.funct7 == 7'h20) begin
                    op = `CORE_OP_SRA;
                end
            end
        end
    end

    // Undecodable words are taken and dropped
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            dec.valid <= 1'b0;
        end else if (accept) begin
            dec.valid <= legal;
        end else if (dec.ready) begin
            dec.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec.op      <= op;
            dec.rd      <= i_instr.r.rd;
            dec.rs1     <= i_instr.r.rs1;
            // x0 never matches a producer
            dec.rs2     <= is_imm ? '0 : i_instr.r.rs2;
            dec.imm     <= imm_ext;
            dec.use_imm <= is_imm;
        end
    end

endmodule

/* logic/execute_stage.sv */
`include "core_defines.svh"

module execute_stage (
    input  logic                    clk,
    input  logic                    resetn,
    dec_ex_if.consumer              dec,
    ex_res_if.producer              res,
    bypass_if.reader                byp,
    output logic [`CORE_REG_AW-1:0] o_rs1_sel,
    output logic [`CORE_REG_AW-1:0] o_rs2_sel,
    input  logic [`CORE_XLEN-1:0]   i_rs1_data,
    input  logic [`CORE_XLEN-1:0]   i_rs2_data
);

    localparam int SHAMT_W = $clog2(`CORE_XLEN);

    logic                  own_vv;
    logic                  stall_a;
    logic                  stall_b;
    logic                  take;
    logic                  is_mul;
    logic                  lt_s;
    logic                  lt_u;
    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] rs2_val;
    logic [`CORE_XLEN-1:0] op_b;
    logic [SHAMT_W-1:0]    shamt;
    logic [`CORE_XLEN-1:0] alu_result;

    // Older producer first, own register overrides it
    function automatic void fwd_operand(
        input  logic [`CORE_REG_AW-1:0] sel,
        input  logic [`CORE_XLEN-1:0]   rf_data,
        output logic [`CORE_XLEN-1:0]   data,
        output logic                    stall
    );
        data  = rf_data;
        stall = 1'b0;
        if (sel != '0 && byp.rd_valid && byp.rd == sel) begin
            if (byp.value_valid) begin
                data = byp.value;
            end else begin
                stall = 1'b1;
            end
        end
        if (sel != '0 && res.valid && res.rd == sel) begin
            if (own_vv) begin
                data = res.value;
            end else begin
                stall = 1'b1;
            end
        end
    endfunction

    assign o_rs1_sel = dec.rs1;
    assign o_rs2_sel = dec.rs2;

    always_comb begin
        fwd_operand(dec.rs1, i_rs1_data, op_a, stall_a);
        fwd_operand(dec.rs2, i_rs2_data, rs2_val, stall_b);
    end

    assign dec.ready = !(stall_a || stall_b) && (!res.valid || res.ready);
    assign take      = dec.valid && dec.ready;
    assign is_mul    = dec.op == `CORE_OP_MUL;

    assign op_b  = dec.use_imm ? dec.imm : rs2_val;
    assign shamt = op_b[SHAMT_W-1:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;

    always_comb begin
        case (dec.op)
            `CORE_OP_ADD:  alu_result = op_a + op_b;
            `CORE_OP_SUB:  alu_result = op_a - op_b;
            `CORE_OP_SLL:  alu_result = op_a << shamt;
            `CORE_OP_SLT:  alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_s};
            `CORE_OP_SLTU: alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_u};
            `CORE_OP_XOR:  alu_result = op_a ^ op_b;
            `CORE_OP_SRL:  alu_result = op_a >> shamt;
            `CORE_OP_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
            `CORE_OP_OR:   alu_result = op_a | op_b;
            `CORE_OP_AND:  alu_result = op_a & op_b;
            // MUL hands its first factor on
            default:       alu_result = op_a;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            res.valid <= 1'b0;
            own_vv    <= 1'b0;
        end else begin
            if (res.valid && res.ready) begin
                res.valid <= 1'b0;
            end
            if (take) begin
                res.valid <= 1'b1;
                own_vv    <= !is_mul;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res.op        <= dec.op;
            res.rd        <= dec.rd;
            res.value     <= alu_result;
            res.operand_b <= op_b;
        end
    end

endmodule

/* logic/reg_file.sv */
`include "core_defines.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic [`CORE_REG_AW-1:0] i_ra_sel,
    input  logic [`CORE_REG_AW-1:0] i_rb_sel,
    output logic [`CORE_XLEN-1:0]   o_ra_data,
    output logic [`CORE_XLEN-1:0]   o_rb_data,
    input  logic                    i_w_en,
    input  logic [`CORE_REG_AW-1:0] i_w_sel,
    input  logic [`CORE_XLEN-1:0]   i_w_data
);

    localparam int NREGS = 1 << `CORE_REG_AW;

    // x0 has no storage
    logic [`CORE_XLEN-1:0] regs [1:NREGS-1];

    assign o_ra_data = (i_ra_sel == '0) ? '0 : regs[i_ra_sel];
    assign o_rb_data = (i_rb_sel == '0) ? '0 : regs[i_rb_sel];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_w_en && i_w_sel != '0) begin
            regs[i_w_sel] <= i_w_data;
        end
    end

endmodule

/* logic/result_stage.sv */
`include "core_defines.svh"

module result_stage (
    input  logic                    clk,
    input  logic                    resetn,
    ex_res_if.consumer              res,
    bypass_if.source                byp,
    output logic                    o_commit_valid,
    output logic [`CORE_REG_AW-1:0] o_commit_rd,
    output logic [`CORE_XLEN-1:0]   o_commit_data
);

    localparam int MUL_STEPS = `CORE_MUL_STEPS;
    localparam int CNT_W     = $clog2(MUL_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(MUL_STEPS - 1);

    logic                    busy_q;
    logic                    done_q;
    logic [CNT_W-1:0]        step_q;
    logic [`CORE_REG_AW-1:0] rd_q;
    logic [`CORE_XLEN-1:0]   acc_q;
    logic [`CORE_XLEN-1:0]   mcand_q;
    logic [`CORE_XLEN-1:0]   mplier_q;
    logic                    take;
    logic                    commit;
    logic                    is_mul;
    logic                    mul_run;

    assign commit    = busy_q && done_q;
    assign mul_run   = busy_q && !done_q;
    assign res.ready = !busy_q || commit;
    assign take      = res.valid && res.ready;
    assign is_mul    = res.op == `CORE_OP_MUL;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            step_q <= '0;
        end else if (take) begin
            busy_q <= 1'b1;
            done_q <= !is_mul;
            step_q <= '0;
        end else if (commit) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (mul_run) begin
            step_q <= step_q + 1'b1;
            if (step_q == LAST_STEP) begin
                done_q <= 1'b1;
            end
        end
    end

    // Shift-and-add, low half of the product only
    always_ff @(posedge clk) begin
        if (take) begin
            rd_q     <= res.rd;
            acc_q    <= is_mul ? '0 : res.value;
            mcand_q  <= res.value;
            mplier_q <= res.operand_b;
        end else if (mul_run) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign byp.rd_valid    = busy_q;
    assign byp.value_valid = done_q;
    assign byp.rd          = rd_q;
    assign byp.value       = acc_q;

    // Also the register file write port
    assign o_commit_valid = commit;
    assign o_commit_rd    = rd_q;
    assign o_commit_data  = acc_q;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module core_tb -Mdir obj_dir -o core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* src.f */
+incdir+include
logic/core_pkg.sv
logic/core_ifs.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/core_top.sv
verif/core_tb.sv

/* verif/core_tb.sv */
`include "core_defines.svh"

module core_tb;
    import core_pkg::*;

    localparam int N_WORDS = 400;
    localparam int TIMEOUT = 200;

    logic                    clk;
    logic                    resetn;
    logic                    instr_valid;
    instr_u                  instr;
    logic                    instr_ready;
    logic                    commit_valid;
    logic [`CORE_REG_AW-1:0] commit_rd;
    logic [`CORE_XLEN-1:0]   commit_data;

    integer seed;
    int     value_errors;
    int     other_errors;
    int     commits_seen;
    int     words_legal;
    logic   timed_out;

    // Sequential reference state and pending commits
    logic [`CORE_XLEN-1:0]   model_regs [0:31];
    logic [`CORE_REG_AW-1:0] exp_rd [$];
    logic [`CORE_XLEN-1:0]   exp_data [$];

    core_top core_top_i (
        .clk            (clk),
        .resetn         (resetn),
        .i_instr_valid  (instr_valid),
        .i_instr        (instr),
        .o_instr_ready  (instr_ready),
        .o_commit_valid (commit_valid),
        .o_commit_rd    (commit_rd),
        .o_commit_data  (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [`CORE_XLEN-1:0] rv32_alu(input logic [2:0] f3, input logic alt,
                                                      input logic [`CORE_XLEN-1:0] a,
                                                      input logic [`CORE_XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    rv32_alu = alt ? a - b : a + b;
            3'd1:    rv32_alu = a << sh;
            3'd2:    rv32_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    rv32_alu = (a < b) ? 32'd1 : 32'd0;
            3'd4:    rv32_alu = a ^ b;
            3'd5:    rv32_alu = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    rv32_alu = a | b;
            default: rv32_alu = a & b;
        endcase
    endfunction

    // RV32 meaning of a word, zero when it makes no commit
    function automatic logic predict(input logic [31:0] w, output logic [`CORE_XLEN-1:0] val);
        logic [6:0]            f7;
        logic [2:0]            f3;
        logic [`CORE_XLEN-1:0] a;
        logic [`CORE_XLEN-1:0] b;
        f7      = w[31:25];
        f3      = w[14:12];
        a       = model_regs[w[19:15]];
        val     = '0;
        predict = 1'b0;
        if (w[6:0] == `CORE_OPC_OP) begin
            b = model_regs[w[24:20]];
            if (f7 == 7'h01 && f3 == 3'd0) begin
                val     = a * b;
                predict = 1'b1;
            end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                val     = rv32_alu(f3, f7[5], a, b);
                predict = 1'b1;
            end
        end else if (w[6:0] == `CORE_OPC_OP_IMM) begin
            b = {{20{w[31]}}, w[31:20]};
            if (f3 == 3'd1) begin
                predict = f7 == 7'h00;
            end else if (f3 == 3'd5) begin
                predict = f7 == 7'h00 || f7 == 7'h20;
            end else begin
                predict = 1'b1;
            end
            val = rv32_alu(f3, f3 == 3'd5 && f7[5], a, b);
        end
    endfunction

    // Registers x0 to x7 only, for dense dependencies
    function automatic logic [31:0] random_word();
        logic [31:0] r;
        logic [31:0] kind;
        logic [6:0]  f7;
        logic [11:0] imm;
        r    = $random(seed);
        kind = $unsigned($random(seed)) % 10;
        f7   = (r[24] && (r[11:9] == 3'd0 || r[11:9] == 3'd5)) ? 7'h20 : 7'h00;
        imm  = r[23:12];
        if (r[11:9] == 3'd1) begin
            imm[11:5] = 7'h00;
        end else if (r[11:9] == 3'd5) begin
            imm[11:5] = r[24] ? 7'h20 : 7'h00;
        end
        if (kind < 4) begin
            random_word = {f7, 2'b00, r[8:6], 2'b00, r[5:3], r[11:9], 2'b00, r[2:0], `CORE_OPC_OP};
        end else if (kind < 7) begin
            random_word = {imm, 2'b00, r[5:3], r[11:9], 2'b00, r[2:0], `CORE_OPC_OP_IMM};
        end else if (kind < 9) begin
            random_word = {7'h01, 2'b00, r[8:6], 2'b00, r[5:3], 3'd0, 2'b00, r[2:0], `CORE_OPC_OP};
        end else if (r[25]) begin
            random_word = {7'h7f, 2'b00, r[8:6], 2'b00, r[5:3], r[11:9], 2'b00, r[2:0], `CORE_OPC_OP};
        end else begin
            // Branch opcode, not decoded here
            random_word = {r[31:7], 7'b1100011};
        end
    endfunction

    task automatic check_rd(input logic [`CORE_REG_AW-1:0] got,
                            input logic [`CORE_REG_AW-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: commit rd is x%0d, expected x%0d", $time, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_data(input logic [`CORE_XLEN-1:0] got,
                              input logic [`CORE_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: commit data is %h, expected %h", $time, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // Ready does not depend on valid, so the falling edge sees the coming handshake
    task automatic send_word(input logic [31:0] w);
        int                    waited;
        logic [`CORE_XLEN-1:0] val;
        waited      = 0;
        instr_valid = 1'b1;
        instr       = w;
        while (!instr_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!instr_ready) begin
            $display("Timeout: input word %h was not accepted in %0d cycles", w, TIMEOUT);
            other_errors++;
            timed_out = 1'b1;
        end else if (predict(w, val)) begin
            exp_rd.push_back(w[11:7]);
            exp_data.push_back(val);
            if (w[11:7] != 5'd0) begin
                model_regs[w[11:7]] = val;
            end
            words_legal++;
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    // Commit monitor, also covers the reset window
    initial begin
        forever begin
            @(negedge clk);
            if (commit_valid) begin
                commits_seen++;
                if (exp_rd.size() == 0) begin
                    $display("Unexpected commit to x%0d at time %0t", commit_rd, $time);
                    other_errors++;
                end else begin
                    check_rd(commit_rd, exp_rd.pop_front());
                    check_data(commit_data, exp_data.pop_front());
                end
            end
        end
    end

    initial begin
        int idle;
        int waited;
        seed         = 32'hdb1f;
        resetn       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        value_errors = 0;
        other_errors = 0;
        commits_seen = 0;
        words_legal  = 0;
        timed_out    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        repeat (5) @(negedge clk);
        check_flag(instr_ready, 1'b1, "o_instr_ready after reset");

        for (int n = 0; n < N_WORDS && !timed_out; n++) begin
            idle = int'($unsigned($random(seed)) % 6);
            if (idle > 2) begin
                idle = 0;
            end
            repeat (idle) @(negedge clk);
            send_word(random_word());
        end

        waited = 0;
        while (exp_rd.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_rd.size() != 0) begin
            $display("Timeout: %0d expected commits never arrived", exp_rd.size());
            other_errors++;
        end
        // Quiet window to catch stray commits
        repeat (2 * `CORE_MUL_STEPS) @(negedge clk);
        if (commits_seen != words_legal) begin
            $display("Commit count %0d differs from decodable words %0d", commits_seen,
                     words_legal);
            other_errors++;
        end

        $display("Commits %0d, decodable words %0d, value errors %0d, other errors %0d",
                 commits_seen, words_legal, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
